//--- Makefile
TOP := rename_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- hw/free_list.sv
`default_nettype none

module free_list (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         pop,
    input  logic                         push,
    input  logic [rename_pkg::TAG_W-1:0] push_tag,
    output logic [rename_pkg::TAG_W-1:0] free_tag
);
    import rename_pkg::*;

    localparam int PTR_W      = $clog2(FREE_DEPTH);
    localparam int INIT_COUNT = FREE_LAST - FREE_FIRST + 1;

    logic [TAG_W-1:0] fifo_mem [FREE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;  // one extra bit to tell full from empty

    assign free_tag = fifo_mem[head];  // next tag handed out

    // storage is preloaded, so it shares the reset with the pointers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fifo_mem[i] <= (i < INIT_COUNT) ? TAG_W'(FREE_FIRST + i) : '0;
            end
            head <= '0;
            tail <= PTR_W'(INIT_COUNT);
        end else begin
            if (pop) begin
                head <= head + 1'b1;  // wraps at depth
            end
            if (push) begin
                fifo_mem[tail] <= push_tag;
                tail           <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= (PTR_W+1)'(INIT_COUNT);
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> count != '0)
        else $error("free_list: pop while empty");

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (push && !pop) |-> count != (PTR_W+1)'(FREE_DEPTH))
        else $error("free_list: push while full");

endmodule

`default_nettype wire

//--- hw/inst_decode.sv
`default_nettype none

module inst_decode (
    input  logic [31:0]                  instr,
    output logic [rename_pkg::LOG_W-1:0] rs1,
    output logic [rename_pkg::LOG_W-1:0] rs2,
    output logic [rename_pkg::LOG_W-1:0] rd,
    output logic                         uses_rs1,
    output logic                         uses_rs2,
    output logic                         writes_rd
);
    import rv_isa_pkg::*;
    import rename_pkg::*;

    logic [OPCODE_W-1:0] opcode;

    assign opcode = instr[OPCODE_W-1:0];

    // field positions are fixed across formats
    assign rs1 = instr[RS1_LSB +: LOG_W];
    assign rs2 = instr[RS2_LSB +: LOG_W];
    assign rd  = instr[RD_LSB +: LOG_W];

    always_comb begin
        uses_rs1  = 1'b1;  // r-type and unknown opcodes use everything
        uses_rs2  = 1'b1;
        writes_rd = 1'b1;
        case (opcode)
            OP_LUI, OP_AUIPC, OP_JAL: begin
                uses_rs1 = 1'b0;  // immediate or pc based
                uses_rs2 = 1'b0;
            end
            OP_JALR, OP_LOAD, OP_IMM: begin
                uses_rs2 = 1'b0;  // rs2 bits hold immediate
            end
            OP_BRANCH, OP_STORE: begin
                writes_rd = 1'b0;  // rd bits hold immediate
            end
            default: begin
            end
        endcase
    end

    // the class flags feed the tag selects in the map table
    always_comb begin
        if (!$isunknown(instr)) begin
            a_flags_known: assert (!$isunknown({uses_rs1, uses_rs2, writes_rd}))
                else $error("inst_decode: operand class unknown for known instr");
        end
    end

endmodule

`default_nettype wire

//--- hw/map_table.sv
`default_nettype none

module map_table (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          id_on,
    input  logic                          restore_state,
    input  logic [rename_pkg::LOG_W-1:0]  rs1,
    input  logic [rename_pkg::LOG_W-1:0]  rs2,
    input  logic [rename_pkg::LOG_W-1:0]  rd,
    input  logic                          uses_rs1,
    input  logic                          uses_rs2,
    input  logic                          writes_rd,
    input  logic [rename_pkg::TAG_W-1:0]  free_tag,
    input  logic [rename_pkg::MAP_W-1:0]  page_flat,
    output logic [rename_pkg::MAP_W-1:0]  map_flat,
    output logic                          free_pop,
    output logic                          free_push,
    output logic [rename_pkg::TAG_W-1:0]  push_tag,
    output logic                          rename_valid,
    output logic [rename_pkg::TAG_W-1:0]  src1_tag,
    output logic [rename_pkg::TAG_W-1:0]  src2_tag,
    output logic [rename_pkg::TAG_W-1:0]  rd_tag,
    output logic [rename_pkg::TAG_W-1:0]  released_tag,
    output logic [rename_pkg::LOG_W-1:0]  rd_log
);
    import rename_pkg::*;

    logic [TAG_W-1:0] tbl [NUM_LOG];
    logic             accept;
    logic             remap;

    assign accept = id_on && !restore_state;  // restore wins over rename
    assign remap  = accept && writes_rd;

    // one tag in, one tag out per remap
    assign free_pop  = remap;
    assign free_push = remap;
    assign push_tag  = tbl[rd];  // old mapping of rd

    always_comb begin
        for (int k = 0; k < NUM_LOG; k++) begin
            map_flat[k*TAG_W +: TAG_W] = tbl[k];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < NUM_LOG; k++) begin
                tbl[k] <= TAG_W'(k);  // identity map
            end
        end else if (restore_state) begin
            for (int k = 0; k < NUM_LOG; k++) begin
                tbl[k] <= page_flat[k*TAG_W +: TAG_W];
            end
        end else if (remap) begin
            tbl[rd] <= free_tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rename_valid <= 1'b0;
        end else begin
            rename_valid <= accept;  // one cycle pulse per rename
        end
    end

    // lookups see the table before this rename's own remap
    always_ff @(posedge clk) begin
        if (accept) begin
            src1_tag <= uses_rs1 ? tbl[rs1] : TAG_NONE_SRC;
            src2_tag <= uses_rs2 ? tbl[rs2] : TAG_NONE_SRC;
            rd_log   <= rd;
            if (writes_rd) begin
                rd_tag       <= free_tag;
                released_tag <= tbl[rd];
            end else begin
                rd_tag       <= TAG_NONE_DST;
                released_tag <= TAG_NONE_DST;
            end
        end
    end

    // free list occupancy only holds if every pop is paired with a push
    a_push_pop_pair: assert property (@(posedge clk) disable iff (reset)
        free_push == free_pop)
        else $error("map_table: free list push and pop out of step");

endmodule

`default_nettype wire

//--- hw/rat_checkpoints.sv
`default_nettype none

module rat_checkpoints (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          save_state,
    input  logic [rename_pkg::PAGE_W-1:0] save_page,
    input  logic [rename_pkg::PAGE_W-1:0] restore_page,
    input  logic [rename_pkg::MAP_W-1:0]  map_flat,
    output logic [rename_pkg::MAP_W-1:0]  page_flat
);
    import rename_pkg::*;

    logic [MAP_W-1:0] pages [NUM_PAGES];

    // whole table snapshot in one edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int p = 0; p < NUM_PAGES; p++) begin
                pages[p] <= '0;
            end
        end else if (save_state) begin
            pages[save_page] <= map_flat;  // map_flat is the pre-rename table
        end
    end

    // read is combinational, so a same-page save lands after the restore samples
    assign page_flat = pages[restore_page];

endmodule

`default_nettype wire

//--- hw/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int LOG_W   = 5;
    localparam int NUM_LOG = 32;
    localparam int TAG_W   = 8;

    localparam logic [TAG_W-1:0] TAG_NONE_SRC = 8'd254;  // operand not read
    localparam logic [TAG_W-1:0] TAG_NONE_DST = 8'd255;  // no destination

    // tags above the identity map that start out free
    localparam int FREE_FIRST = 32;
    localparam int FREE_LAST  = 253;
    localparam int FREE_DEPTH = 256;  // power of two, pointers wrap

    localparam int NUM_PAGES = 16;
    localparam int PAGE_W    = 4;

    // whole table flattened, entry k at bits [k*TAG_W +: TAG_W]
    localparam int MAP_W = NUM_LOG * TAG_W;

endpackage

`default_nettype wire

//--- hw/rename_top.sv
`default_nettype none

module rename_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          id_on,
    input  logic                          save_state,
    input  logic                          restore_state,
    input  logic [rename_pkg::PAGE_W-1:0] save_page,
    input  logic [rename_pkg::PAGE_W-1:0] restore_page,
    input  logic [31:0]                   instr,
    output logic                          rename_valid,
    output logic [rename_pkg::TAG_W-1:0]  src1_tag,
    output logic [rename_pkg::TAG_W-1:0]  src2_tag,
    output logic [rename_pkg::TAG_W-1:0]  rd_tag,
    output logic [rename_pkg::LOG_W-1:0]  rd_log,
    output logic [rename_pkg::TAG_W-1:0]  released_tag
);
    import rename_pkg::*;

    logic [LOG_W-1:0] rs1;
    logic [LOG_W-1:0] rs2;
    logic [LOG_W-1:0] rd;
    logic             uses_rs1;
    logic             uses_rs2;
    logic             writes_rd;
    logic [TAG_W-1:0] free_tag;
    logic [TAG_W-1:0] push_tag;
    logic             free_pop;
    logic             free_push;
    logic [MAP_W-1:0] map_flat;
    logic [MAP_W-1:0] page_flat;

    inst_decode u_decode (
        .instr     (instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .uses_rs1  (uses_rs1),
        .uses_rs2  (uses_rs2),
        .writes_rd (writes_rd)
    );

    map_table u_map (
        .clk           (clk),
        .reset         (reset),
        .id_on         (id_on),
        .restore_state (restore_state),
        .rs1           (rs1),
        .rs2           (rs2),
        .rd            (rd),
        .uses_rs1      (uses_rs1),
        .uses_rs2      (uses_rs2),
        .writes_rd     (writes_rd),
        .free_tag      (free_tag),
        .page_flat     (page_flat),
        .map_flat      (map_flat),
        .free_pop      (free_pop),
        .free_push     (free_push),
        .push_tag      (push_tag),
        .rename_valid  (rename_valid),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .rd_tag        (rd_tag),
        .released_tag  (released_tag),
        .rd_log        (rd_log)
    );

    rat_checkpoints u_ckpt (
        .clk          (clk),
        .reset        (reset),
        .save_state   (save_state),
        .save_page    (save_page),
        .restore_page (restore_page),
        .map_flat     (map_flat),
        .page_flat    (page_flat)
    );

    free_list u_free (
        .clk      (clk),
        .reset    (reset),
        .pop      (free_pop),
        .push     (free_push),
        .push_tag (push_tag),
        .free_tag (free_tag)
    );

endmodule

`default_nettype wire

//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int OPCODE_W = 7;

    // bit positions of the register fields
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    // upper immediate forms, no source read
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;

    // single source forms
    localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;

    // two sources, nothing written back
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;

    // register-register alu
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;

endpackage

`default_nettype wire

//--- test/rename_tb.sv
`default_nettype none

module rename_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rename_pkg::*;
    import rv_isa_pkg::*;

    localparam int RANDOM_CYCLES = 3000;
    localparam int RESET_TIMEOUT = 20;

    logic              clk = 1'b0;
    logic              reset;
    logic              id_on;
    logic              save_state;
    logic              restore_state;
    logic [PAGE_W-1:0] save_page;
    logic [PAGE_W-1:0] restore_page;
    logic [31:0]       instr;
    logic              rename_valid;
    logic [TAG_W-1:0]  src1_tag;
    logic [TAG_W-1:0]  src2_tag;
    logic [TAG_W-1:0]  rd_tag;
    logic [LOG_W-1:0]  rd_log;
    logic [TAG_W-1:0]  released_tag;

    // reference model of table, pages and free FIFO
    logic [TAG_W-1:0] m_tbl [NUM_LOG];
    logic [TAG_W-1:0] m_pages [NUM_PAGES][NUM_LOG];
    logic [TAG_W-1:0] m_free [$];

    // what the DUT should show after the next edge
    logic             exp_valid;
    logic [TAG_W-1:0] exp_src1;
    logic [TAG_W-1:0] exp_src2;
    logic [TAG_W-1:0] exp_rd;
    logic [TAG_W-1:0] exp_rel;
    logic [LOG_W-1:0] exp_rd_log;

    logic [31:0]         lfsr_state;
    logic [OPCODE_W-1:0] opcodes [9];
    string               test_name;
    int                  mismatch_count;
    int                  timeout_count;

    rename_top dut (
        .clk           (clk),
        .reset         (reset),
        .id_on         (id_on),
        .save_state    (save_state),
        .restore_state (restore_state),
        .save_page     (save_page),
        .restore_page  (restore_page),
        .instr         (instr),
        .rename_valid  (rename_valid),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .rd_tag        (rd_tag),
        .rd_log        (rd_log),
        .released_tag  (released_tag)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_instr(input logic [OPCODE_W-1:0] op,
                                               input logic [LOG_W-1:0] rd,
                                               input logic [LOG_W-1:0] rs1,
                                               input logic [LOG_W-1:0] rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, op};
    endfunction

    task automatic model_reset();
        for (int k = 0; k < NUM_LOG; k++) begin
            m_tbl[k] = TAG_W'(k);  // identity map
            for (int p = 0; p < NUM_PAGES; p++) begin
                m_pages[p][k] = '0;
            end
        end
        m_free.delete();
        for (int t = FREE_FIRST; t <= FREE_LAST; t++) begin
            m_free.push_back(TAG_W'(t));
        end
        exp_valid = 1'b0;
    endtask

    // apply one cycle of inputs to the model, pre-edge table used everywhere
    task automatic model_step(input logic on, input logic [31:0] ins, input logic sv,
                              input logic [PAGE_W-1:0] svp, input logic rs,
                              input logic [PAGE_W-1:0] rsp);
        logic [OPCODE_W-1:0] op;
        logic [LOG_W-1:0]    r1;
        logic [LOG_W-1:0]    r2;
        logic [LOG_W-1:0]    rd;
        logic                u1;
        logic                u2;
        logic                wr;
        logic [TAG_W-1:0]    new_tag;
        logic [TAG_W-1:0]    next_tbl [NUM_LOG];
        op = ins[6:0];
        rd = ins[11:7];
        r1 = ins[19:15];
        r2 = ins[24:20];
        u1 = !(op inside {OP_LUI, OP_AUIPC, OP_JAL});
        u2 = u1 && !(op inside {OP_JALR, OP_LOAD, OP_IMM});
        wr = !(op inside {OP_BRANCH, OP_STORE});
        exp_valid = on && !rs;
        for (int k = 0; k < NUM_LOG; k++) begin
            next_tbl[k] = rs ? m_pages[rsp][k] : m_tbl[k];  // old page content on collision
        end
        if (exp_valid) begin
            exp_src1   = u1 ? m_tbl[r1] : TAG_NONE_SRC;
            exp_src2   = u2 ? m_tbl[r2] : TAG_NONE_SRC;
            exp_rd_log = rd;
            exp_rd     = TAG_NONE_DST;
            exp_rel    = TAG_NONE_DST;
            if (wr) begin
                new_tag = m_free.pop_front();
                m_free.push_back(m_tbl[rd]);  // released at once
                exp_rd       = new_tag;
                exp_rel      = m_tbl[rd];
                next_tbl[rd] = new_tag;
            end
        end
        if (sv) begin
            for (int k = 0; k < NUM_LOG; k++) begin
                m_pages[svp][k] = m_tbl[k];
            end
        end
        for (int k = 0; k < NUM_LOG; k++) begin
            m_tbl[k] = next_tbl[k];
        end
    endtask

    task automatic compare(input string field, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("Mismatch %s %s: expected %0d, actual %0d",
                     test_name, field, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_outputs();
        compare("rename_valid", 32'(exp_valid), 32'(rename_valid));
        if (exp_valid) begin
            compare("src1_tag", 32'(exp_src1), 32'(src1_tag));
            compare("src2_tag", 32'(exp_src2), 32'(src2_tag));
            compare("rd_tag", 32'(exp_rd), 32'(rd_tag));
            compare("rd_log", 32'(exp_rd_log), 32'(rd_log));
            compare("released_tag", 32'(exp_rel), 32'(released_tag));
        end
    endtask

    // outputs checked at the falling edge belong to the previous call's inputs
    task automatic do_cycle(input logic on, input logic [31:0] ins, input logic sv,
                            input logic [PAGE_W-1:0] svp, input logic rs,
                            input logic [PAGE_W-1:0] rsp);
        @(posedge clk);
        id_on         <= on;
        instr         <= ins;
        save_state    <= sv;
        save_page     <= svp;
        restore_state <= rs;
        restore_page  <= rsp;
        @(negedge clk);
        check_outputs();
        model_step(on, ins, sv, svp, rs, rsp);
    endtask

    task automatic rename_only(input logic [31:0] ins);
        do_cycle(1'b1, ins, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic wait_reset_release(output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            ok = !reset;
            waited++;
        end
        if (!ok) begin
            $display("Timeout: reset was never released");
            timeout_count++;
        end
    endtask

    task automatic run_directed();
        test_name = "identity";
        for (int k = 0; k < NUM_LOG; k++) begin
            rename_only(make_instr(OP_REG, LOG_W'(k), LOG_W'((k + 1) % NUM_LOG), LOG_W'(k)));
        end
        test_name = "sentinels";
        for (int i = 0; i < 9; i++) begin
            rename_only(make_instr(opcodes[i], 5'd3, 5'd4, 5'd5));
        end
        test_name = "fifo_order";  // wraps past the 222 entry queue
        for (int i = 0; i < 230; i++) begin
            rename_only(make_instr(OP_REG, LOG_W'(i % NUM_LOG), LOG_W'(i % 7), LOG_W'(i % 11)));
        end
        test_name = "checkpoint";
        do_cycle(1'b1, make_instr(OP_REG, 5'd5, 5'd5, 5'd6), 1'b1, 4'd3, 1'b0, '0);
        rename_only(make_instr(OP_REG, 5'd6, 5'd5, 5'd6));
        rename_only(make_instr(OP_IMM, 5'd5, 5'd6, 5'd0));
        do_cycle(1'b1, make_instr(OP_REG, 5'd7, 5'd5, 5'd6), 1'b0, '0, 1'b1, 4'd3);
        rename_only(make_instr(OP_REG, 5'd8, 5'd5, 5'd6));
        do_cycle(1'b1, make_instr(OP_REG, 5'd5, 5'd5, 5'd6), 1'b1, 4'd3, 1'b1, 4'd3);
        rename_only(make_instr(OP_REG, 5'd9, 5'd5, 5'd6));
        test_name = "unsaved_page";
        do_cycle(1'b0, '0, 1'b0, '0, 1'b1, 4'd15);
        rename_only(make_instr(OP_REG, 5'd9, 5'd1, 5'd2));
    endtask

    task automatic run_random();
        logic [31:0] upper;
        logic [31:0] sv_page;
        logic [31:0] rs_page;
        logic        on;
        logic        sv;
        logic        rs;
        int          idx;
        test_name = "random";
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            idx     = int'(rand_bits(4) % 9);
            upper   = rand_bits(25);
            on      = rand_bits(2) != 0;  // about 75 percent
            sv      = rand_bits(5) == 0;
            sv_page = rand_bits(PAGE_W);
            rs      = rand_bits(7) == 0;  // rarer than save
            rs_page = rand_bits(PAGE_W);
            do_cycle(on, {upper[24:0], opcodes[idx]}, sv, sv_page[PAGE_W-1:0],
                     rs, rs_page[PAGE_W-1:0]);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        logic ok;
        reset          = 1'b1;
        id_on          = 1'b0;
        save_state     = 1'b0;
        restore_state  = 1'b0;
        save_page      = '0;
        restore_page   = '0;
        instr          = '0;
        lfsr_state     = 32'hc3a6;
        mismatch_count = 0;
        timeout_count  = 0;
        opcodes = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD,
                    OP_IMM, OP_BRANCH, OP_STORE, OP_REG};
        model_reset();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait_reset_release(ok);
        if (ok) begin
            run_directed();
            run_random();
            do_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);  // flush last rename
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/rv_isa_pkg.sv
hw/rename_pkg.sv
hw/inst_decode.sv
hw/rat_checkpoints.sv
hw/map_table.sv
hw/free_list.sv
hw/rename_top.sv
test/rename_tb.sv
